// File: pi_pkg.sv
// widths, fixed-point split, dac register code, loop state enum and shared structs.
package pi_pkg;

  ////////////////////////////////////////////////////////////
  // sample and error widths.
  ////////////////////////////////////////////////////////////
  localparam int adc_wid = 18;                       // two's complement adc sample.
  localparam int err_wid = adc_wid + 1;              // measured minus setpoint, no overflow.

  // coefficients are 15.33 fixed point, scaled to adc steps.
  localparam int consts_wid  = 48;
  localparam int consts_frac = 33;
  localparam int mul_wid     = consts_wid + err_wid; // full booth product.
  localparam int sum_wid     = mul_wid + 1;          // room for a_p + ae - pe_p.

  ////////////////////////////////////////////////////////////
  // dac frame layout.
  ////////////////////////////////////////////////////////////
  localparam int dac_data_wid  = 20;
  localparam int dac_frame_wid = 24;
  localparam logic [3:0] dac_code = 4'b0010;         // dac data register write.
  localparam int keep_frac = dac_data_wid - adc_wid; // fraction bits kept for the dac.

  localparam int delay_wid = 16;                     // clk cycles between iterations.

  typedef enum logic [2:0] {
    idle,   // waiting for arm.
    delay,  // iteration spacing.
    adc,    // conversion pulse and sample read.
    mul,    // both multipliers running.
    dac     // frame going out.
  } loop_state_t;

  // inputs from software, captured at the start of each iteration.
  typedef struct packed {
    logic signed [adc_wid-1:0]    setpt;  // adc units.
    logic signed [consts_wid-1:0] alpha;  // p + i*dt.
    logic signed [consts_wid-1:0] p;
    logic [delay_wid-1:0]         delay;
  } loop_cfg_t;

  // live view of the loop registers.
  typedef struct packed {
    logic signed [err_wid-1:0] err_cur;
    logic signed [sum_wid-1:0] adj;   // full precision output history.
  } loop_status_t;

endpackage

// File: loop_fsm.sv
// loop sequencer FSM with start strobes, clear control and timer span check.
`timescale 1ns/1ns

module loop_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         arm,
  input  logic [pi_pkg::delay_wid-1:0] delay,
  input  logic                         timer_done,
  input  logic                         adc_done,
  input  logic                         mul_done,
  input  logic                         dac_done,
  output logic                         timer_start,
  output logic                         capture,
  output logic                         clear,
  output logic                         adc_start,
  output logic                         mul_start,
  output logic                         dac_start,
  output pi_pkg::loop_state_t          state
);

  logic [pi_pkg::delay_wid-1:0] span_cnt; // follows the timer count.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= pi_pkg::idle;
      timer_start <= 1'b0;
      capture     <= 1'b0;
      clear       <= 1'b0;
      adc_start   <= 1'b0;
      mul_start   <= 1'b0;
      dac_start   <= 1'b0;
    end else begin
      timer_start <= 1'b0; // all strobes are single cycle.
      capture     <= 1'b0;
      clear       <= 1'b0;
      adc_start   <= 1'b0;
      mul_start   <= 1'b0;
      dac_start   <= 1'b0;
      case (state)
        pi_pkg::idle: begin
          if (arm) begin
            capture     <= 1'b1;  // latch setpoint and coefficients.
            timer_start <= 1'b1;  // timer loads delay on the same edge.
            state       <= pi_pkg::delay;
          end else begin
            clear <= 1'b1;        // disarmed, drop the history.
          end
        end
        pi_pkg::delay: if (timer_done) begin
          adc_start <= 1'b1;
          state     <= pi_pkg::adc;
        end
        pi_pkg::adc: if (adc_done) begin
          mul_start <= 1'b1;      // sample is held by the reader.
          state     <= pi_pkg::mul;
        end
        pi_pkg::mul: if (mul_done) begin
          dac_start <= 1'b1;
          state     <= pi_pkg::dac;
        end
        pi_pkg::dac: if (dac_done) state <= pi_pkg::idle;
        default: state <= pi_pkg::idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // span bookkeeping against the timer.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (timer_start) begin
      span_cnt <= delay;
    end else if (state == pi_pkg::delay) begin
      span_cnt <= span_cnt - 1'b1;
    end
  end

  a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({timer_start, adc_start, mul_start, dac_start}));

  // timer_done lands exactly max(delay, 1) cycles after timer_start.
  a_timer_span: assert property (@(posedge clk) disable iff (!rst_n)
    (state == pi_pkg::delay && !timer_start) |->
      (timer_done == (span_cnt[pi_pkg::delay_wid-1:1] == '0)));

endmodule

// File: loop_timer.sv
// down-counter spacing loop iterations by the captured delay.
`timescale 1ns/1ns

module loop_timer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic [pi_pkg::delay_wid-1:0] count,
  output logic                         done
);

  logic [pi_pkg::delay_wid-1:0] cnt;
  logic busy;

  always_ff @(posedge clk) begin
    if (!rst_n) busy <= 1'b0;
    else if (start) busy <= 1'b1;
    else if (done) busy <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (start) cnt <= count;                // count sampled with the strobe.
    else if (busy) cnt <= cnt - 1'b1;
  end

  // ends at one; a zero count also ends on the first cycle.
  assign done = busy && (cnt[pi_pkg::delay_wid-1:1] == '0);

endmodule

// File: spi_adc_reader.sv
// read-only SPI master with conversion pulse for one signed adc sample.
`timescale 1ns/1ns

module spi_adc_reader (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start,
  input  logic                              miso,
  output logic                              sck,
  output logic                              conv,
  output logic                              done,
  output logic signed [pi_pkg::adc_wid-1:0] sample
);

  logic [1:0] tick;                         // 4 clk per bit.
  logic shifting;
  logic [pi_pkg::adc_wid-1:0] shreg;
  logic [pi_pkg::adc_wid-1:0] bits_left;    // thermometer, one bit per sck.
  logic rise;
  logic last;

  assign rise = shifting && (tick == 2'd1);
  assign last = shifting && (tick == 2'd3) && !bits_left[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      conv     <= 1'b0;
      shifting <= 1'b0;
      sck      <= 1'b0;
      done     <= 1'b0;
      tick     <= 2'd0;
    end else begin
      done <= 1'b0;
      tick <= tick + 1'b1;
      if (start && !conv && !shifting) begin
        conv <= 1'b1;                       // conversion pulse, 2 clk.
        tick <= 2'd0;
      end else if (conv) begin
        if (tick == 2'd1) begin
          conv     <= 1'b0;
          shifting <= 1'b1;
          tick     <= 2'd0;
        end
      end else if (shifting) begin
        if (rise) sck <= 1'b1;              // miso sampled on this edge.
        if (tick == 2'd3) sck <= 1'b0;      // adc moves data on the fall.
        if (last) begin
          shifting <= 1'b0;
          done     <= 1'b1;
        end
      end
    end
  end

  // shift path, msb first.
  always_ff @(posedge clk) begin
    if (conv) bits_left <= '1;
    else if (shifting && tick == 2'd3) bits_left <= bits_left >> 1;
    if (rise) shreg <= {shreg[pi_pkg::adc_wid-2:0], miso};
    if (last) sample <= shreg;              // held until the next read.
  end

  a_sck_idle_in_conv: assert property (@(posedge clk) disable iff (!rst_n)
    conv |-> !sck);

endmodule

// File: booth_mul.sv
// sequential radix-2 booth multiplier, coefficient times error.
`timescale 1ns/1ns

module booth_mul (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  logic signed [pi_pkg::consts_wid-1:0] a,
  input  logic signed [pi_pkg::err_wid-1:0]    b,
  output logic signed [pi_pkg::mul_wid-1:0]    prod,
  output logic                                 done
);

  // one guard bit on the upper half so subtracting -2^47 cannot wrap.
  logic signed [pi_pkg::consts_wid:0] hi;
  logic signed [pi_pkg::consts_wid:0] mcand;
  logic signed [pi_pkg::consts_wid:0] sum;
  logic [pi_pkg::err_wid-1:0] lo;             // multiplier bits, shifted out lsb first.
  logic [pi_pkg::err_wid-1:0] left;           // thermometer of remaining steps.
  logic q_m1;                                 // booth look-behind bit.

  always_comb begin
    case ({lo[0], q_m1})
      2'b10:   sum = hi - mcand;              // entering a run of ones.
      2'b01:   sum = hi + mcand;              // leaving a run.
      default: sum = hi;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      left <= '0;
      done <= 1'b0;
    end else begin
      done <= left[0] && !left[1];            // last step in flight.
      if (start) left <= '1;
      else left <= left >> 1;
    end
  end

  // datapath, one bit of b per cycle.
  always_ff @(posedge clk) begin
    if (start) begin
      mcand <= {a[pi_pkg::consts_wid-1], a};
      hi    <= '0;
      lo    <= b;
      q_m1  <= 1'b0;
    end else if (left[0]) begin
      hi   <= {sum[pi_pkg::consts_wid], sum[pi_pkg::consts_wid:1]}; // arithmetic shift.
      lo   <= {sum[0], lo[pi_pkg::err_wid-1:1]};
      q_m1 <= lo[0];
    end
  end

  assign prod = {hi[pi_pkg::consts_wid-1:0], lo}; // guard bit is pure sign here.

  a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(start, pi_pkg::err_wid + 1));

endmodule

// File: pi_update.sv
// PI update with coefficient capture, error history, two multipliers and saturation.
`timescale 1ns/1ns

module pi_update (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   capture,
  input  logic                                   clear,
  input  logic signed [pi_pkg::adc_wid-1:0]      sample,
  input  logic                                   mul_start,
  input  pi_pkg::loop_cfg_t                      cfg,
  output logic                                   mul_done,
  output logic signed [pi_pkg::dac_data_wid-1:0] dac_val,
  output pi_pkg::loop_status_t                   status
);

  localparam int drop = pi_pkg::consts_frac - pi_pkg::keep_frac; // low bits discarded.

  logic signed [pi_pkg::adc_wid-1:0]    setpt_q;
  logic signed [pi_pkg::consts_wid-1:0] alpha_q;
  logic signed [pi_pkg::consts_wid-1:0] p_q;
  logic signed [pi_pkg::err_wid-1:0]    err_now;
  logic signed [pi_pkg::err_wid-1:0]    err_q;
  logic signed [pi_pkg::err_wid-1:0]    err_prev;
  logic signed [pi_pkg::mul_wid-1:0]    alpha_err;
  logic signed [pi_pkg::mul_wid-1:0]    p_err_prev;
  logic signed [pi_pkg::sum_wid-1:0]    adj_q;    // previous output a_p.
  logic signed [pi_pkg::sum_wid-1:0]    adj_next;
  logic signed [pi_pkg::sum_wid-drop-1:0] rtrunc; // 35 whole bits, 2 fraction bits.
  logic alpha_done;
  logic p_done;

  // coefficients frozen for the whole iteration.
  always_ff @(posedge clk) begin
    if (capture) begin
      setpt_q <= cfg.setpt;
      alpha_q <= cfg.alpha;
      p_q     <= cfg.p;
    end
  end

  assign err_now = {sample[pi_pkg::adc_wid-1], sample} - {setpt_q[pi_pkg::adc_wid-1], setpt_q};

  ////////////////////////////////////////////////////////////
  // error and output history.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (mul_start) err_q <= err_now;              // same value alpha*e uses.
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      adj_q    <= '0;
      err_prev <= '0;
    end else if (mul_done) begin
      adj_q    <= adj_next;
      err_prev <= err_q;
    end
  end

  booth_mul alpha_mul_i (.clk(clk), .rst_n(rst_n), .start(mul_start), .a(alpha_q),
                         .b(err_now), .prod(alpha_err), .done(alpha_done));
  booth_mul p_mul_i (.clk(clk), .rst_n(rst_n), .start(mul_start), .a(p_q),
                     .b(err_prev), .prod(p_err_prev), .done(p_done));

  assign mul_done = alpha_done & p_done;          // both finish together.

  // a = a_p + alpha*e - p*e_p.
  assign adj_next = adj_q + {alpha_err[pi_pkg::mul_wid-1], alpha_err}
                          - {p_err_prev[pi_pkg::mul_wid-1], p_err_prev};

  ////////////////////////////////////////////////////////////
  // truncate, then saturate into 20 dac bits.
  ////////////////////////////////////////////////////////////
  assign rtrunc = adj_q[pi_pkg::sum_wid-1:drop];

  always_comb begin
    if (&rtrunc[pi_pkg::sum_wid-drop-1:pi_pkg::dac_data_wid-1] ||
        ~|rtrunc[pi_pkg::sum_wid-drop-1:pi_pkg::dac_data_wid-1]) begin
      dac_val = rtrunc[pi_pkg::dac_data_wid-1:0];  // fits.
    end else if (rtrunc[pi_pkg::sum_wid-drop-1]) begin
      dac_val = {1'b1, {(pi_pkg::dac_data_wid-1){1'b0}}}; // clamp low.
    end else begin
      dac_val = {1'b0, {(pi_pkg::dac_data_wid-1){1'b1}}}; // clamp high.
    end
  end

  assign status = '{err_cur: err_q, adj: adj_q};

endmodule

// File: spi_dac_writer.sv
// write-only SPI master shifting one dac frame under slave select.
`timescale 1ns/1ns

module spi_dac_writer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  logic [pi_pkg::dac_frame_wid-1:0] frame,
  output logic                             sck,
  output logic                             ss,
  output logic                             mosi,
  output logic                             done
);

  logic [2:0] tick;                                // 8 clk per bit.
  logic busy;
  logic [pi_pkg::dac_frame_wid-1:0] shreg;
  logic [pi_pkg::dac_frame_wid-1:0] bits_left;     // thermometer, one bit per sck.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      ss   <= 1'b1;
      sck  <= 1'b0;
      done <= 1'b0;
      tick <= 3'd0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy <= 1'b1;
        ss   <= 1'b0;                              // msb already on mosi.
        tick <= 3'd0;
      end else if (busy) begin
        tick <= tick + 1'b1;
        if (tick == 3'd3) sck <= 1'b1;             // dac samples on the rise.
        if (tick == 3'd7) begin
          sck <= 1'b0;
          if (!bits_left[1]) begin                 // last bit done.
            busy <= 1'b0;
            ss   <= 1'b1;
            done <= 1'b1;
          end
        end
      end
    end
  end

  // data moves on the falling sck edge.
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      shreg     <= frame;
      bits_left <= '1;
    end else if (busy && tick == 3'd7) begin
      shreg     <= shreg << 1;
      bits_left <= bits_left >> 1;
    end
  end

  assign mosi = shreg[pi_pkg::dac_frame_wid-1];

  // select window opens on start and closes one full frame of bits later.
  a_ss_open: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ss) |-> $past(start));
  a_ss_close: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ss) |-> $past(start, pi_pkg::dac_frame_wid * 8 + 1));

endmodule

// File: pi_loop_top.sv
// top level wiring of sequencer, timer, adc reader, PI update and dac writer.
`timescale 1ns/1ns

module pi_loop_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 arm,
  input  pi_pkg::loop_cfg_t    cfg,
  output logic                 adc_sck,
  output logic                 adc_conv,
  input  logic                 adc_in,
  output logic                 dac_sck,
  output logic                 dac_ss,
  output logic                 dac_out,
  output pi_pkg::loop_status_t status
);

  logic timer_start, timer_done;                   // fsm strobes and block replies.
  logic capture, clear;
  logic adc_start, adc_done;
  logic mul_start, mul_done;
  logic dac_start, dac_done;
  logic signed [pi_pkg::adc_wid-1:0]      sample;
  logic signed [pi_pkg::dac_data_wid-1:0] dac_val;
  pi_pkg::loop_state_t state;

  loop_fsm fsm_i (.clk(clk), .rst_n(rst_n), .arm(arm), .delay(cfg.delay),
    .timer_done(timer_done), .adc_done(adc_done), .mul_done(mul_done),
    .dac_done(dac_done), .timer_start(timer_start), .capture(capture), .clear(clear),
    .adc_start(adc_start), .mul_start(mul_start), .dac_start(dac_start), .state(state));

  loop_timer timer_i (.clk(clk), .rst_n(rst_n), .start(timer_start), .count(cfg.delay),
    .done(timer_done));

  spi_adc_reader adc_i (.clk(clk), .rst_n(rst_n), .start(adc_start), .miso(adc_in),
    .sck(adc_sck), .conv(adc_conv), .done(adc_done), .sample(sample));

  pi_update upd_i (.clk(clk), .rst_n(rst_n), .capture(capture), .clear(clear),
    .sample(sample), .mul_start(mul_start), .cfg(cfg), .mul_done(mul_done),
    .dac_val(dac_val), .status(status));

  // register code ahead of the 20 data bits.
  spi_dac_writer dac_i (.clk(clk), .rst_n(rst_n), .start(dac_start),
    .frame({pi_pkg::dac_code, dac_val}), .sck(dac_sck), .ss(dac_ss), .mosi(dac_out),
    .done(dac_done));

  // spi activity stays inside its fsm phase.
  a_dac_phase: assert property (@(posedge clk) disable iff (!rst_n)
    !dac_ss |-> state == pi_pkg::dac);
  a_adc_phase: assert property (@(posedge clk) disable iff (!rst_n)
    adc_conv |-> state == pi_pkg::adc);

endmodule

// File: tb_clock.sv
// testbench clock generator and power-on reset.
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;        // 40 ns period.
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);     // two cycles in reset.
    #5 rst_n = 1'b1;
  end

endmodule

// File: tb_pi_loop.sv
// directed testbench for the PI loop with adc model, dac capture, reference model and checks.
`timescale 1ns/1ns

module tb_pi_loop;

  localparam logic [pi_pkg::delay_wid-1:0] base_delay = 16'd3;
  localparam int max_delay = 32;
  // conversion, adc bits, booth steps, dac bits, spacing and fsm hops.
  localparam int iter_cycles = 2 + pi_pkg::adc_wid * 4 + pi_pkg::err_wid
                               + pi_pkg::dac_frame_wid * 8 + max_delay + 24;
  localparam int cycle_limit = 12 * iter_cycles;   // twelve iterations in all tests.

  logic clk;
  logic rst_n;
  logic arm;
  pi_pkg::loop_cfg_t cfg;
  logic adc_sck, adc_conv, dac_sck, dac_ss, dac_out;
  logic adc_in = 1'b0;
  pi_pkg::loop_status_t status;

  logic signed [pi_pkg::adc_wid-1:0] adc_word;      // value the adc model returns.
  logic [pi_pkg::dac_frame_wid-1:0] frame_sh = '0;
  logic [pi_pkg::dac_frame_wid-1:0] frame_got = '0;
  int frame_cnt = 0;
  int cycle = 0;
  int ss_rise_cyc = 0;
  int conv_gap = 0;                                 // cycles from dac_ss rise to adc_conv rise.
  int conv_cnt = 0;
  logic ss_prev = 1'b1;
  logic conv_prev = 1'b0;
  int err_cnt;
  logic [31:0] rng_state;
  logic signed [pi_pkg::sum_wid-1:0] ref_adj;       // reference output history.
  logic signed [pi_pkg::err_wid-1:0] ref_eprev;     // reference error history.

  tb_clock clk_gen_i (.clk(clk), .rst_n(rst_n));

  pi_loop_top dut_i (.clk(clk), .rst_n(rst_n), .arm(arm), .cfg(cfg), .adc_sck(adc_sck),
    .adc_conv(adc_conv), .adc_in(adc_in), .dac_sck(dac_sck), .dac_ss(dac_ss),
    .dac_out(dac_out), .status(status));

  ////////////////////////////////////////////////////////////
  // adc model, dac capture, monitors and timeout.
  ////////////////////////////////////////////////////////////
  always begin
    @(posedge adc_conv);
    @(negedge adc_conv);
    for (int i = pi_pkg::adc_wid - 1; i >= 0; i--) begin
      #5 adc_in = adc_word[i];                      // msb first, ready before the sck rise.
      if (i > 0) @(negedge adc_sck);
    end
  end

  always @(posedge dac_sck) begin
    if (!dac_ss) frame_sh <= {frame_sh[pi_pkg::dac_frame_wid-2:0], dac_out};
  end

  always @(posedge dac_ss) begin
    if (rst_n === 1'b1) begin                       // skip the reset edge.
      frame_got = frame_sh;
      frame_cnt++;
    end
  end

  // edges seen at the falling clk, away from the register updates.
  always @(negedge clk) begin
    if (dac_ss && !ss_prev) ss_rise_cyc = cycle;
    if (adc_conv && !conv_prev) begin
      conv_gap = cycle - ss_rise_cyc;
      conv_cnt++;
    end
    ss_prev = dac_ss;
    conv_prev = adc_conv;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > cycle_limit) begin
      $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
      $display("Errors found");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers and reference model.
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // lcg step.
    return rng_state;
  endfunction

  function automatic pi_pkg::loop_cfg_t pack_cfg(input logic signed [pi_pkg::adc_wid-1:0] st,
      input logic signed [pi_pkg::consts_wid-1:0] alpha,
      input logic signed [pi_pkg::consts_wid-1:0] p,
      input logic [pi_pkg::delay_wid-1:0] dly);
    pi_pkg::loop_cfg_t c;
    c.setpt = st;
    c.alpha = alpha;
    c.p = p;
    c.delay = dly;
    return c;
  endfunction

  // measured minus setpoint, one extra bit.
  function automatic logic signed [pi_pkg::err_wid-1:0] error_of(
      input logic signed [pi_pkg::adc_wid-1:0] smp, input logic signed [pi_pkg::adc_wid-1:0] st);
    logic signed [pi_pkg::err_wid-1:0] s_w;
    logic signed [pi_pkg::err_wid-1:0] t_w;
    s_w = smp;
    t_w = st;
    return s_w - t_w;
  endfunction

  // incremental form, a = a_prev + alpha*e - p*e_prev.
  function automatic logic signed [pi_pkg::sum_wid-1:0] adj_after(
      input logic signed [pi_pkg::sum_wid-1:0] a_prev, input pi_pkg::loop_cfg_t c,
      input logic signed [pi_pkg::err_wid-1:0] e, input logic signed [pi_pkg::err_wid-1:0] e_prev);
    logic signed [pi_pkg::sum_wid-1:0] alpha_w, p_w, e_w, ep_w;
    alpha_w = c.alpha;
    p_w = c.p;
    e_w = e;
    ep_w = e_prev;
    return a_prev + alpha_w * e_w - p_w * ep_w;
  endfunction

  // keep two fraction bits, clamp to the 20-bit dac range.
  function automatic logic [pi_pkg::dac_frame_wid-1:0] frame_for(
      input logic signed [pi_pkg::sum_wid-1:0] a);
    logic signed [pi_pkg::sum_wid-1:0] scaled, hi_lim, lo_lim;
    logic [pi_pkg::dac_data_wid-1:0] data;
    scaled = a >>> (pi_pkg::consts_frac - pi_pkg::keep_frac);
    hi_lim = (2 ** (pi_pkg::dac_data_wid - 1)) - 1;
    lo_lim = -(2 ** (pi_pkg::dac_data_wid - 1));
    if (scaled > hi_lim) data = hi_lim[pi_pkg::dac_data_wid-1:0];
    else if (scaled < lo_lim) data = lo_lim[pi_pkg::dac_data_wid-1:0];
    else data = scaled[pi_pkg::dac_data_wid-1:0];
    return {pi_pkg::dac_code, data};
  endfunction

  ////////////////////////////////////////////////////////////
  // checks.
  ////////////////////////////////////////////////////////////
  task automatic check_frame(input logic [pi_pkg::dac_frame_wid-1:0] got,
      input logic [pi_pkg::dac_frame_wid-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR dac frame: got 0x%h, expected 0x%h", got, exp);
      $display("Errors found");
      $fatal(1, "dac frame mismatch");
    end
  endtask

  task automatic check_err(input logic signed [pi_pkg::err_wid-1:0] got,
      input logic signed [pi_pkg::err_wid-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR status.err_cur: got 0x%h, expected 0x%h", got, exp);
      $display("Errors found");
      $fatal(1, "error register mismatch");
    end
  endtask

  task automatic check_adj(input logic signed [pi_pkg::sum_wid-1:0] got,
      input logic signed [pi_pkg::sum_wid-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR status.adj: got 0x%h, expected 0x%h", got, exp);
      $display("Errors found");
      $fatal(1, "output history mismatch");
    end
  endtask

  task automatic check_spacing(input int gap, input int dly, input int gap_prev, input int dly_prev);
    if (gap < dly || (gap_prev >= 0 && gap - gap_prev != dly - dly_prev)) begin
      err_cnt++;
      $display("adc_conv rose %0d cycles after dac_ss with a delay of %0d, which is wrong",
               gap, dly);
      $display("Errors found");
      $fatal(1, "iteration spacing wrong");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // iteration sequencing.
  ////////////////////////////////////////////////////////////
  task automatic start_iteration(input logic signed [pi_pkg::adc_wid-1:0] smp,
      input pi_pkg::loop_cfg_t c);
    @(posedge clk);
    #5;
    adc_word = smp;
    cfg = c;
    arm = 1'b1;
  endtask

  task automatic wait_frame();
    int n;
    n = frame_cnt;
    while (frame_cnt == n) @(negedge clk);
  endtask

  task automatic wait_conv_rise();
    int n;
    n = conv_cnt;
    while (conv_cnt == n) @(negedge clk);
  endtask

  // waits for the frame, compares against the reference and steps the history.
  task automatic finish_iteration(input logic signed [pi_pkg::adc_wid-1:0] smp,
      input pi_pkg::loop_cfg_t used);
    logic signed [pi_pkg::err_wid-1:0] e;
    logic signed [pi_pkg::sum_wid-1:0] a_exp;
    e = error_of(smp, used.setpt);
    a_exp = adj_after(ref_adj, used, e, ref_eprev);
    wait_frame();
    check_frame(frame_got, frame_for(a_exp));
    check_err(status.err_cur, e);
    check_adj(status.adj, a_exp);
    ref_adj = a_exp;
    ref_eprev = e;
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests.
  ////////////////////////////////////////////////////////////
  task automatic first_after_reset();
    pi_pkg::loop_cfg_t c;
    c = pack_cfg(18'sd200, 48'sh3_0000_0000, 48'sh1_0000_0000, base_delay); // 1.5 and 0.5.
    start_iteration(18'sd1000, c);
    finish_iteration(18'sd1000, c);
    check_frame(frame_got, {pi_pkg::dac_code, 20'h012c0});  // 800 * 1.5 in quarter steps.
  endtask

  task automatic accumulate_three();
    logic [31:0] r, r_a, r_p;
    logic signed [pi_pkg::adc_wid-1:0] smp;
    pi_pkg::loop_cfg_t c;
    for (int k = 0; k < 3; k++) begin
      r = next_rand();
      r_a = next_rand();
      r_p = next_rand();
      smp = {{5{r[12]}}, r[12:0]};                // small signal, within 13 bits.
      c = pack_cfg({{6{r[27]}}, r[27:16]}, {16'd0, r_a}, {17'd0, r_p[30:0]}, base_delay);
      start_iteration(smp, c);
      finish_iteration(smp, c);
    end
  endtask

  task automatic saturate_both_rails();
    pi_pkg::loop_cfg_t c;
    c = pack_cfg(18'sh20000, 48'sh4000_0000_0000, 48'sh2000_0000_0000, base_delay);
    start_iteration(18'sh1ffff, c);                // largest positive error.
    finish_iteration(18'sh1ffff, c);
    check_frame(frame_got, {pi_pkg::dac_code, 20'h7ffff});
    c.setpt = 18'sh1ffff;
    start_iteration(18'sh20000, c);                // largest negative error.
    finish_iteration(18'sh20000, c);
    check_frame(frame_got, {pi_pkg::dac_code, 20'h80000});
  endtask

  task automatic disarm_clears_history();
    pi_pkg::loop_cfg_t c;
    c = pack_cfg(18'sd50, 48'sh2_0000_0000, 48'sh1_0000_0000, base_delay);
    start_iteration(18'sd300, c);
    wait_conv_rise();
    @(posedge clk);
    #5 arm = 1'b0;                                  // mid-iteration disarm.
    finish_iteration(18'sd300, c);
    ref_adj = '0;                                   // idle with arm low zeroes the history.
    ref_eprev = '0;
    repeat (4) @(posedge clk);
    start_iteration(-18'sd400, c);
    finish_iteration(-18'sd400, c);
  endtask

  task automatic coeffs_change_mid_run();
    pi_pkg::loop_cfg_t c_old, c_new;
    c_old = pack_cfg(18'sd100, 48'sh1_0000_0000, 48'sh0_8000_0000, base_delay);
    c_new = pack_cfg(-18'sd100, 48'sh4_0000_0000, 48'sh0_8000_0000, base_delay);
    start_iteration(18'sd600, c_old);
    wait_conv_rise();
    @(posedge clk);
    #5 cfg = c_new;                                 // change during the adc phase.
    finish_iteration(18'sd600, c_old);
    start_iteration(18'sd700, c_new);
    finish_iteration(18'sd700, c_new);
  endtask

  task automatic spacing_follows_delay();
    pi_pkg::loop_cfg_t c;
    int gap_short;
    c = pack_cfg(18'sd0, 48'sh2_0000_0000, 48'sh0, 16'd4);
    start_iteration(18'sd10, c);
    finish_iteration(18'sd10, c);
    check_spacing(conv_gap, 4, -1, 0);
    gap_short = conv_gap;
    c.delay = 16'd20;
    start_iteration(-18'sd10, c);
    finish_iteration(-18'sd10, c);
    check_spacing(conv_gap, 20, gap_short, 4);
  endtask

  initial begin
    arm = 1'b0;
    cfg = '0;
    adc_word = '0;
    err_cnt = 0;
    rng_state = 32'hdf7f;
    ref_adj = '0;
    ref_eprev = '0;
    wait (rst_n === 1'b1);
    first_after_reset();
    accumulate_three();
    saturate_both_rails();
    disarm_clears_history();
    coeffs_change_mid_run();
    spacing_follows_delay();
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
pi_pkg.sv
loop_fsm.sv
loop_timer.sv
spi_adc_reader.sv
booth_mul.sv
pi_update.sv
spi_dac_writer.sv
pi_loop_top.sv
tb_clock.sv
tb_pi_loop.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PI loop testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_pi_loop -o tb_pi_loop; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_pi_loop)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
